/* logic/credit_link_pkg.sv */
//--------------------------------------
// Credit link datapath package.
// Holds the flit layout, the default sizes
// and the rule for credit counter widths.
//--------------------------------------
package credit_link_pkg;

  // Default word width carried over the link.
  localparam int default_data_width = 16;

  // Default receive buffer depth.
  // The credit pool starts with exactly this many credits.
  localparam int default_buffer_depth = 8;

  // Width of the data field inside a flit.
  // It follows the default word width, so the top level keeps data_width at this value.
  localparam int flit_data_width = default_data_width;

  // Number of bits that can hold every value from zero up to depth.
  // A depth below one still gets a single bit.
  function automatic int count_width(input int depth);
    return (depth < 1) ? 1 : $clog2(depth + 1);
  endfunction

  //--------------------------------------
  // Link word
  //--------------------------------------

  // One word on the link together with its valid bit.
  // A flit with valid low carries no data and is ignored by the receiver.
  typedef struct packed {
    logic                       valid;
    logic [flit_data_width-1:0] data;
  } flit_t;

endpackage

/* logic/credit_csr_pkg.sv */
//--------------------------------------
// Credit link register package.
// Wishbone classic request and response
// layouts and the register map.
//--------------------------------------
package credit_csr_pkg;

  // Wishbone address and data widths used by the register block.
  localparam int csr_addr_width = 4;
  localparam int csr_data_width = 32;

  // Master to slave signals of one Wishbone classic access.
  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [csr_addr_width-1:0] adr;
    logic [csr_data_width-1:0] dat;
  } wb_req_t;

  // Slave to master signals.
  // The read data is only meaningful while ack is high.
  typedef struct packed {
    logic                      ack;
    logic [csr_data_width-1:0] dat;
  } wb_rsp_t;

  // Register map. Only the withhold register is writable.
  localparam logic [csr_addr_width-1:0] csr_withhold_addr  = 4'h0;
  localparam logic [csr_addr_width-1:0] csr_count_addr     = 4'h1;
  localparam logic [csr_addr_width-1:0] csr_available_addr = 4'h2;
  localparam logic [csr_addr_width-1:0] csr_balance_addr   = 4'h3;

endpackage

/* logic/credit_counter.sv */
//--------------------------------------
// Credit counter.
// Saturating count of credits with a same
// cycle increment, a decrement handshake
// and a dynamic withhold amount.
//--------------------------------------
`timescale 1ns/1ps

module credit_counter #(
  parameter int max_value = 8,
  localparam int count_bits = credit_link_pkg::count_width(max_value)
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  incr_valid,
  input  logic [count_bits-1:0] incr,
  input  logic                  decr_valid,
  output logic                  decr_ready,
  input  logic [count_bits-1:0] withhold,
  output logic [count_bits-1:0] value,
  output logic [count_bits-1:0] available
);

  // One extra bit keeps the intermediate sums free of wrap around.
  logic [count_bits-1:0] count_q;
  logic [count_bits:0]   grown;
  logic [count_bits:0]   avail_wide;
  logic [count_bits:0]   next_wide;
  logic                  decr_taken;

  //--------------------------------------
  // Available credit
  //--------------------------------------

  // The increment of this cycle is already spendable.
  // This lets a returned credit go out again with zero latency.
  assign grown = {1'b0, count_q} + (incr_valid ? {1'b0, incr} : '0);

  // Withheld credits are taken off the top, floored at zero.
  assign avail_wide = (grown > {1'b0, withhold}) ? (grown - {1'b0, withhold}) : '0;
  assign available  = avail_wide[count_bits-1:0];

  // A decrement is only offered when something is left after the withhold.
  assign decr_ready = |avail_wide;
  assign decr_taken = decr_valid & decr_ready;

  //--------------------------------------
  // Count register
  //--------------------------------------

  // Clamp at max_value so a stray extra increment cannot grow the pool.
  assign next_wide = grown - {{count_bits{1'b0}}, decr_taken};

  always_ff @(posedge clk) begin
    if (reset) begin
      count_q <= count_bits'(max_value);
    end else if (next_wide > (count_bits + 1)'(max_value)) begin
      count_q <= count_bits'(max_value);
    end else begin
      count_q <= next_wide[count_bits-1:0];
    end
  end

  // The reported value is the state before this cycle's changes.
  assign value = count_q;

endmodule

/* logic/credit_receiver.sv */
//--------------------------------------
// Credit receiver.
// Grants push credits to the sender from
// its credit pool and forwards flits into
// the receive buffer without registers.
//--------------------------------------
`timescale 1ns/1ps

module credit_receiver #(
  parameter int data_width   = credit_link_pkg::default_data_width,
  parameter int buffer_depth = credit_link_pkg::default_buffer_depth,
  localparam int count_bits  = credit_link_pkg::count_width(buffer_depth)
) (
  input  logic                   clk,
  input  logic                   reset,
  input  credit_link_pkg::flit_t link_flit,
  output logic                   push_credit,
  output credit_link_pkg::flit_t buf_flit,
  input  logic                   pop_credit,
  input  logic [count_bits-1:0]  credit_withhold,
  output logic [count_bits-1:0]  credit_count,
  output logic [count_bits-1:0]  credit_available
);

  import credit_link_pkg::*;

  logic                  reset_released;
  logic                  decr_valid;
  logic                  decr_ready;
  logic [data_width-1:0] fwd_data;

  // Stays low in the first cycle after reset.
  // No credit may leave while the sender could still be in reset.
  always_ff @(posedge clk) begin
    if (reset) begin
      reset_released <= 1'b0;
    end else begin
      reset_released <= 1'b1;
    end
  end

  assign decr_valid = reset_released;

  // The pool starts full at buffer_depth.
  // Every pop of the buffer puts one credit back.
  credit_counter #(
    .max_value (buffer_depth)
  ) i_credit_counter (
    .clk        (clk),
    .reset      (reset),
    .incr_valid (pop_credit),
    .incr       (count_bits'(1)),
    .decr_valid (decr_valid),
    .decr_ready (decr_ready),
    .withhold   (credit_withhold),
    .value      (credit_count),
    .available  (credit_available)
  );

  // At most one credit goes out per cycle.
  assign push_credit = decr_valid & decr_ready;

  // The datapath is a straight pass with zero cycles of latency.
  assign fwd_data = data_width'(link_flit.data);
  assign buf_flit = '{valid: link_flit.valid, data: flit_data_width'(fwd_data)};

endmodule

/* logic/credit_sender.sv */
//--------------------------------------
// Credit sender.
// Tracks the credit balance and launches
// accepted upstream words as registered
// flits on the link.
//--------------------------------------
`timescale 1ns/1ps

module credit_sender #(
  parameter int data_width   = credit_link_pkg::default_data_width,
  parameter int buffer_depth = credit_link_pkg::default_buffer_depth,
  localparam int count_bits  = credit_link_pkg::count_width(buffer_depth)
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   in_valid,
  input  logic [data_width-1:0]  in_data,
  output logic                   in_ready,
  input  logic                   push_credit,
  output credit_link_pkg::flit_t link_flit,
  output logic [count_bits-1:0]  sender_balance
);

  import credit_link_pkg::*;

  logic [count_bits-1:0] balance_q;
  logic                  accept;
  logic                  flit_valid_q;
  logic [data_width-1:0] flit_data_q;

  // A word is only taken when a credit is already held.
  // A credit arriving this cycle counts from the next cycle on.
  assign in_ready = |balance_q;
  assign accept   = in_valid & in_ready;

  // Credits received minus words launched.
  // It never exceeds buffer_depth since the receiver owns the pool.
  always_ff @(posedge clk) begin
    if (reset) begin
      balance_q <= '0;
    end else begin
      balance_q <= balance_q + count_bits'(push_credit) - count_bits'(accept);
    end
  end

  assign sender_balance = balance_q;

  // The valid bit follows each accepted word by one cycle.
  always_ff @(posedge clk) begin
    if (reset) begin
      flit_valid_q <= 1'b0;
    end else begin
      flit_valid_q <= accept;
    end
  end

  // Data is only loaded on accept and ignored while valid is low.
  always_ff @(posedge clk) begin
    if (accept) begin
      flit_data_q <= in_data;
    end
  end

  assign link_flit = '{valid: flit_valid_q, data: flit_data_width'(flit_data_q)};

endmodule

/* logic/receive_buffer.sv */
//--------------------------------------
// Receive buffer.
// Circular FIFO behind the credit receiver.
// Each word that leaves returns a credit.
//--------------------------------------
`timescale 1ns/1ps

module receive_buffer #(
  parameter int data_width   = credit_link_pkg::default_data_width,
  parameter int buffer_depth = credit_link_pkg::default_buffer_depth,
  localparam int count_bits  = credit_link_pkg::count_width(buffer_depth),
  localparam int ptr_bits    = (buffer_depth > 1) ? $clog2(buffer_depth) : 1
) (
  input  logic                   clk,
  input  logic                   reset,
  input  credit_link_pkg::flit_t buf_flit,
  output logic                   out_valid,
  output logic [data_width-1:0]  out_data,
  input  logic                   out_ready,
  output logic                   pop_credit
);

  logic [data_width-1:0] mem [buffer_depth];
  logic [ptr_bits-1:0]   wr_ptr;
  logic [ptr_bits-1:0]   rd_ptr;
  logic [count_bits-1:0] fill;
  logic                  push;

  // Advance a pointer and wrap after the last entry.
  // The depth does not have to be a power of two.
  function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
    return (ptr == ptr_bits'(buffer_depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // The sender holds a credit for every flit, so there is always room.
  assign push       = buf_flit.valid;
  assign out_valid  = |fill;
  assign pop_credit = out_valid & out_ready;
  assign out_data   = mem[rd_ptr];

  //--------------------------------------
  // Pointers and fill level
  //--------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop_credit) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      fill <= fill + count_bits'(push) - count_bits'(pop_credit);
    end
  end

  // Storage has no reset. Unwritten entries are never read.
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= data_width'(buf_flit.data);
    end
  end

endmodule

/* logic/credit_csr.sv */
//--------------------------------------
// Credit link register block.
// Wishbone classic slave with the withhold
// register and credit status readback.
//--------------------------------------
`timescale 1ns/1ps

module credit_csr #(
  parameter int buffer_depth = credit_link_pkg::default_buffer_depth,
  localparam int count_bits  = credit_link_pkg::count_width(buffer_depth)
) (
  input  logic                   clk,
  input  logic                   reset,
  input  credit_csr_pkg::wb_req_t wb_req,
  output credit_csr_pkg::wb_rsp_t wb_rsp,
  output logic [count_bits-1:0]  credit_withhold,
  input  logic [count_bits-1:0]  credit_count,
  input  logic [count_bits-1:0]  credit_available,
  input  logic [count_bits-1:0]  sender_balance
);

  import credit_csr_pkg::*;

  logic                      ack_q;
  logic                      access_start;
  logic [count_bits-1:0]     withhold_q;
  logic [csr_data_width-1:0] read_data;
  logic [csr_data_width-1:0] rdata_q;

  // A new access starts when the strobe is up and no ack is pending.
  // The master holds stb until ack, so this fires once per access.
  assign access_start = wb_req.cyc & wb_req.stb & ~ack_q;

  // Address decode for reads. Unmapped addresses read as zero.
  always_comb begin
    case (wb_req.adr)
      csr_withhold_addr:  read_data = csr_data_width'(withhold_q);
      csr_count_addr:     read_data = csr_data_width'(credit_count);
      csr_available_addr: read_data = csr_data_width'(credit_available);
      csr_balance_addr:   read_data = csr_data_width'(sender_balance);
      default:            read_data = '0;
    endcase
  end

  // Ack comes one cycle after the strobe rises and lasts one cycle.
  always_ff @(posedge clk) begin
    if (reset) begin
      ack_q      <= 1'b0;
      withhold_q <= '0;
    end else begin
      ack_q <= access_start;
      if (access_start && wb_req.we && (wb_req.adr == csr_withhold_addr)) begin
        withhold_q <= wb_req.dat[count_bits-1:0];
      end
    end
  end

  // Read data is captured with the access and shown in the ack cycle.
  always_ff @(posedge clk) begin
    if (access_start) begin
      rdata_q <= read_data;
    end
  end

  assign wb_rsp          = '{ack: ack_q, dat: rdata_q};
  assign credit_withhold = withhold_q;

endmodule

/* logic/credit_link_top.sv */
//--------------------------------------
// Credit link top level.
// Sender, receiver, receive buffer and
// register block on one clock.
//--------------------------------------
`timescale 1ns/1ps

module credit_link_top #(
  parameter int data_width   = credit_link_pkg::default_data_width,
  parameter int buffer_depth = credit_link_pkg::default_buffer_depth
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    in_valid,
  input  logic [data_width-1:0]   in_data,
  output logic                    in_ready,
  output logic                    out_valid,
  output logic [data_width-1:0]   out_data,
  input  logic                    out_ready,
  input  credit_csr_pkg::wb_req_t wb_req,
  output credit_csr_pkg::wb_rsp_t wb_rsp
);

  import credit_link_pkg::*;

  localparam int count_bits = count_width(buffer_depth);

  flit_t                 link_flit;
  flit_t                 buf_flit;
  logic                  push_credit;
  logic                  pop_credit;
  logic [count_bits-1:0] credit_withhold;
  logic [count_bits-1:0] credit_count;
  logic [count_bits-1:0] credit_available;
  logic [count_bits-1:0] sender_balance;

  credit_sender #(
    .data_width   (data_width),
    .buffer_depth (buffer_depth)
  ) i_credit_sender (
    .clk            (clk),
    .reset          (reset),
    .in_valid       (in_valid),
    .in_data        (in_data),
    .in_ready       (in_ready),
    .push_credit    (push_credit),
    .link_flit      (link_flit),
    .sender_balance (sender_balance)
  );

  credit_receiver #(
    .data_width   (data_width),
    .buffer_depth (buffer_depth)
  ) i_credit_receiver (
    .clk              (clk),
    .reset            (reset),
    .link_flit        (link_flit),
    .push_credit      (push_credit),
    .buf_flit         (buf_flit),
    .pop_credit       (pop_credit),
    .credit_withhold  (credit_withhold),
    .credit_count     (credit_count),
    .credit_available (credit_available)
  );

  // Buffer pops feed straight back into the receiver's credit pool.
  receive_buffer #(
    .data_width   (data_width),
    .buffer_depth (buffer_depth)
  ) i_receive_buffer (
    .clk        (clk),
    .reset      (reset),
    .buf_flit   (buf_flit),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_ready  (out_ready),
    .pop_credit (pop_credit)
  );

  credit_csr #(
    .buffer_depth (buffer_depth)
  ) i_credit_csr (
    .clk              (clk),
    .reset            (reset),
    .wb_req           (wb_req),
    .wb_rsp           (wb_rsp),
    .credit_withhold  (credit_withhold),
    .credit_count     (credit_count),
    .credit_available (credit_available),
    .sender_balance   (sender_balance)
  );

endmodule

/* testbench/credit_link_tb.sv */
//--------------------------------------
// Credit link testbench.
// Directed tests of the credit link top level
// with a scoreboard on the downstream port.
//--------------------------------------
`timescale 1ns/1ps

module credit_link_tb;

  import credit_link_pkg::*;
  import credit_csr_pkg::*;

  localparam int data_width   = default_data_width;
  localparam int buffer_depth = default_buffer_depth;
  localparam int wait_limit   = 200;
  localparam int stall_cycles = 20;

  logic                  clk;
  logic                  reset;
  logic                  in_valid;
  logic [data_width-1:0] in_data;
  logic                  in_ready;
  logic                  out_valid;
  logic [data_width-1:0] out_data;
  logic                  out_ready;
  wb_req_t               wb_req;
  wb_rsp_t               wb_rsp;

  // Scoreboard of words taken upstream and not yet seen downstream.
  logic [data_width-1:0] expected_q[$];
  logic [31:0]           lcg_state;
  string                 current_test;

  credit_link_top #(
    .data_width   (data_width),
    .buffer_depth (buffer_depth)
  ) i_credit_link_top (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //--------------------------------------
  // Helpers
  //--------------------------------------

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string label, input int expected, input int actual);
    assert (actual == expected) else
      fail_run($sformatf("ERR %s %s: expected %0h, actual %0h",
                         current_test, label, expected, actual));
  endtask

  // Linear congruential generator for the data words.
  function automatic logic [data_width-1:0] next_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31 -: data_width];
  endfunction

  // Every task starts and ends 1 ns after a rising edge.
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // One Wishbone classic access. Ack is sampled at the falling edge.
  task automatic wb_access(input logic write, input logic [3:0] adr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited      = 0;
    wb_req.cyc  = 1'b1;
    wb_req.stb  = 1'b1;
    wb_req.we   = write;
    wb_req.adr  = adr;
    wb_req.dat  = wdata;
    @(negedge clk);
    while (!wb_rsp.ack) begin
      if (waited == wait_limit) fail_run("timeout: Wishbone ack never came");
      waited++;
      @(negedge clk);
    end
    rdata = wb_rsp.dat;
    next_cycle();
    wb_req = '0;
  endtask

  task automatic wb_write(input logic [3:0] adr, input logic [31:0] wdata);
    logic [31:0] unused;
    wb_access(1'b1, adr, wdata, unused);
  endtask

  task automatic wb_read(input logic [3:0] adr, output logic [31:0] rdata);
    wb_access(1'b0, adr, '0, rdata);
  endtask

  // Polls the sender balance until it settles at the target.
  task automatic wait_balance(input int target);
    logic [31:0] value;
    int          tries;
    tries = 0;
    wb_read(csr_balance_addr, value);
    while (value != target) begin
      if (tries == wait_limit)
        fail_run($sformatf("timeout: sender balance never reached %0d", target));
      tries++;
      wb_read(csr_balance_addr, value);
    end
  endtask

  // Offers one word and holds it until in_ready takes it.
  task automatic send_word(input logic [data_width-1:0] data);
    int waited;
    waited   = 0;
    in_valid = 1'b1;
    in_data  = data;
    @(negedge clk);
    while (!in_ready) begin
      if (waited == wait_limit) fail_run("timeout: in_ready stayed low while sending");
      waited++;
      @(negedge clk);
    end
    expected_q.push_back(data);
    next_cycle();
    in_valid = 1'b0;
  endtask

  // Keeps offering words until in_ready has been low for stall_cycles in a row.
  task automatic fill_until_stall(output int accepted);
    int                    idle;
    logic [data_width-1:0] data;
    accepted = 0;
    idle     = 0;
    data     = next_word();
    in_valid = 1'b1;
    in_data  = data;
    while (idle < stall_cycles) begin
      if (accepted > 2 * buffer_depth) fail_run("in_ready never fell under back-pressure");
      @(negedge clk);
      if (in_ready) begin
        expected_q.push_back(data);
        accepted++;
        idle = 0;
        next_cycle();
        data    = next_word();
        in_data = data;
      end else begin
        idle++;
        next_cycle();
      end
    end
    in_valid = 1'b0;
  endtask

  // Opens the downstream port and waits for the scoreboard to empty.
  task automatic drain_all();
    int waited;
    waited    = 0;
    out_ready = 1'b1;
    while (expected_q.size() != 0) begin
      if (waited == wait_limit) fail_run("timeout: buffer did not drain");
      waited++;
      next_cycle();
    end
    @(negedge clk);
    check_value("out_valid after drain", 0, out_valid);
    next_cycle();
  endtask

  // Every downstream transfer must match the oldest word sent.
  always @(negedge clk) begin
    logic [data_width-1:0] expected;
    if (!reset && out_valid && out_ready) begin
      assert (expected_q.size() > 0) else
        fail_run($sformatf("word %0h came out of %s but none was sent", out_data,
                           current_test));
      expected = expected_q.pop_front();
      check_value("out_data", expected, out_data);
    end
  end

  //--------------------------------------
  // Tests
  //--------------------------------------

  task automatic test_reset_state();
    int          waited;
    logic [31:0] value;
    current_test = "reset_state";
    waited       = 0;
    @(negedge clk);
    check_value("in_ready", 0, in_ready);
    check_value("out_valid", 0, out_valid);
    check_value("ack", 0, wb_rsp.ack);
    while (!in_ready) begin
      if (waited == stall_cycles) fail_run("timeout: in_ready did not rise after reset");
      waited++;
      @(negedge clk);
    end
    check_value("out_valid", 0, out_valid);
    next_cycle();
    wait_balance(buffer_depth);
    wb_read(csr_balance_addr, value);
    check_value("sender balance", buffer_depth, value);
  endtask

  task automatic test_streaming();
    current_test = "streaming";
    out_ready    = 1'b1;
    repeat (40) send_word(next_word());
    drain_all();
  endtask

  task automatic test_back_pressure();
    int accepted;
    current_test = "back_pressure";
    out_ready    = 1'b0;
    fill_until_stall(accepted);
    check_value("accepted words", buffer_depth, accepted);
    drain_all();
    wait_balance(buffer_depth);
  endtask

  // The receiver keeps W credits back once they have come home through pops.
  task automatic test_withhold();
    logic [31:0] value;
    int          accepted;
    current_test = "withhold";
    wb_write(csr_withhold_addr, 32'd3);
    wb_read(csr_withhold_addr, value);
    check_value("withhold readback", 3, value);
    out_ready = 1'b1;
    repeat (buffer_depth) send_word(next_word());
    drain_all();
    wait_balance(buffer_depth - 3);
    out_ready = 1'b0;
    fill_until_stall(accepted);
    check_value("accepted words", buffer_depth - 3, accepted);
    drain_all();
    wb_write(csr_withhold_addr, 32'd0);
    wait_balance(buffer_depth);
  endtask

  // Credits held by the sender and the receiver plus the stalled words make up the pool.
  task automatic test_status();
    localparam int k            = 3;
    localparam int idle_balance = buffer_depth - k;
    logic [31:0] balance;
    logic [31:0] count;
    logic [31:0] available;
    current_test = "status";
    out_ready    = 1'b0;
    repeat (k) send_word(next_word());
    wait_balance(idle_balance);
    wb_read(csr_balance_addr, balance);
    wb_read(csr_count_addr, count);
    wb_read(csr_available_addr, available);
    check_value("balance plus count plus k", buffer_depth, balance + count + k);
    // With withhold zero the pool keeps only what neither the sender nor the buffer holds.
    check_value("available", buffer_depth - k - idle_balance, available);
    drain_all();
    wait_balance(buffer_depth);
  endtask

  //--------------------------------------
  // Main sequence
  //--------------------------------------
  initial begin
    reset          = 1'b1;
    in_valid       = 1'b0;
    in_data        = '0;
    out_ready      = 1'b0;
    wb_req         = '0;
    lcg_state      = 32'hef205352;
    current_test   = "reset";
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    test_reset_state();
    test_streaming();
    test_back_pressure();
    test_withhold();
    test_status();
    $display("TEST PASS");
    $finish;
  end

endmodule

/* vlog.f */
logic/credit_link_pkg.sv
logic/credit_csr_pkg.sv
logic/credit_counter.sv
logic/credit_receiver.sv
logic/credit_sender.sv
logic/receive_buffer.sv
logic/credit_csr.sv
logic/credit_link_top.sv
testbench/credit_link_tb.sv

/* Bender.yml */
package:
  name: credit_link

sources:
  - logic/credit_link_pkg.sv
  - logic/credit_csr_pkg.sv
  - logic/credit_counter.sv
  - logic/credit_receiver.sv
  - logic/credit_sender.sv
  - logic/receive_buffer.sv
  - logic/credit_csr.sv
  - logic/credit_link_top.sv
  - target: test
    files:
      - testbench/credit_link_tb.sv
